// ==== rtl/match_pkg.sv ====
package match_pkg;

	////////////////////////////////////////////////////////////
	// Channel and packet geometry
	////////////////////////////////////////////////////////////

	localparam int NUM_CHAN = 7;         // Compute channels and time slots
	localparam int DATA_W   = 32;        // Packet word

	////////////////////////////////////////////////////////////
	// Result path
	////////////////////////////////////////////////////////////

	localparam int RESULT_W        = 64;
	localparam int FIFO_DEPTH      = 16;
	localparam int FIFO_AW         = $clog2(FIFO_DEPTH);
	localparam int ALMOST_FULL_LVL = 12; // Strictly above this is almost full

endpackage

// ==== rtl/packet_dispatcher.sv ====
`timescale 1ns/1ps

module packet_dispatcher import match_pkg::*; (
	input  logic                              sys_clk,
	input  logic                              sys_rst_n,
	input  logic                              pkt_sop_i,
	input  logic                              pkt_eop_i,
	input  logic                              pkt_vld_i,
	input  logic [DATA_W-1:0]                 pkt_data_i,
	input  logic [NUM_CHAN-1:0]               chan_ready_i,
	input  logic                              fifo_almost_full_i,
	output logic                              pkt_receive_enable_o,
	output logic [NUM_CHAN-1:0]               chan_sop_o,
	output logic [NUM_CHAN-1:0]               chan_eop_o,
	output logic [NUM_CHAN-1:0]               chan_vld_o,
	output logic [NUM_CHAN-1:0][DATA_W-1:0]   chan_data_o
);

	logic [NUM_CHAN-1:0] chan_ptr;          // One-hot, current channel
	logic                cur_ready;
	logic                chan_done;
	logic                ready_q;
	logic                space_q;

	assign cur_ready = |(chan_ready_i & chan_ptr);
	assign chan_done = !cur_ready && !pkt_vld_i;   // Channel busy and bus idle

	////////////////////////////////////////////////////////////
	// Round-robin pointer
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			chan_ptr <= NUM_CHAN'(1);
		end else if (chan_done) begin
			chan_ptr <= {chan_ptr[NUM_CHAN-2:0], chan_ptr[NUM_CHAN-1]};
		end
	end

	////////////////////////////////////////////////////////////
	// Routing into the selected channel
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			chan_sop_o <= '0;
			chan_eop_o <= '0;
			chan_vld_o <= '0;
		end else begin
			chan_sop_o <= chan_ptr & {NUM_CHAN{pkt_sop_i}};
			chan_eop_o <= chan_ptr & {NUM_CHAN{pkt_eop_i}};
			chan_vld_o <= chan_ptr & {NUM_CHAN{pkt_vld_i}};
		end
	end

	always_ff @(posedge sys_clk) begin
		for (int i = 0; i < NUM_CHAN; i++) begin
			chan_data_o[i] <= chan_ptr[i] ? pkt_data_i : '0;   // Idle channels see zero
		end
	end

	////////////////////////////////////////////////////////////
	// Receive enable
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			ready_q <= 1'b0;
			space_q <= 1'b0;
		end else begin
			ready_q <= cur_ready;
			if (pkt_sop_i && fifo_almost_full_i) begin
				space_q <= 1'b0;                    // Hold off new packets
			end else if (!fifo_almost_full_i) begin
				space_q <= 1'b1;
			end
		end
	end

	assign pkt_receive_enable_o = ready_q & space_q;

	a_ptr_onehot: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot(chan_ptr));

	a_sop_enabled: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(pkt_sop_i) |-> pkt_receive_enable_o);

endmodule

// ==== rtl/result_slot_mux.sv ====
`timescale 1ns/1ps

module result_slot_mux import match_pkg::*; (
	input  logic                              sys_clk,
	input  logic                              sys_rst_n,
	input  logic [NUM_CHAN-1:0]               chan_result_vld_i,
	input  logic [NUM_CHAN-1:0][RESULT_W-1:0] chan_result_i,
	output logic                              fifo_wr_en_o,
	output logic [RESULT_W-1:0]               fifo_wr_data_o
);

	logic [NUM_CHAN-1:0] slot;              // Rotating time slot
	logic [RESULT_W-1:0] slot_data;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			slot <= NUM_CHAN'(1);
		end else begin
			slot <= {slot[NUM_CHAN-2:0], slot[NUM_CHAN-1]};
		end
	end

	// One-hot select of the slot owner's result
	always_comb begin
		slot_data = '0;
		for (int i = 0; i < NUM_CHAN; i++) begin
			if (slot[i]) begin
				slot_data = chan_result_i[i];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// FIFO write stage
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			fifo_wr_en_o <= 1'b0;
		end else begin
			fifo_wr_en_o <= |(chan_result_vld_i & slot);   // Only in own slot
		end
	end

	always_ff @(posedge sys_clk) begin
		fifo_wr_data_o <= slot_data;
	end

	a_slot_onehot: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot(slot));

endmodule

// ==== rtl/result_fifo.sv ====
`timescale 1ns/1ps

module result_fifo import match_pkg::*; (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic                wr_en_i,
	input  logic [RESULT_W-1:0] wr_data_i,
	input  logic                rd_en_i,
	output logic [RESULT_W-1:0] rd_data_o,
	output logic [FIFO_AW:0]    count_o,
	output logic                empty_o,
	output logic                full_o,
	output logic                almost_full_o
);

	logic [RESULT_W-1:0] mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0]  wr_ptr;
	logic [FIFO_AW-1:0]  rd_ptr;
	logic                do_wr;
	logic                do_rd;

	assign do_wr = wr_en_i && !full_o;     // Overflow write dropped
	assign do_rd = rd_en_i && !empty_o;

	always_ff @(posedge sys_clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data_i;
		end
		if (do_rd) begin
			rd_data_o <= mem[rd_ptr];           // Registered read port
		end
	end

	////////////////////////////////////////////////////////////
	// Pointers and fill count
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count_o <= count_o + 1'b1;
				2'b01:   count_o <= count_o - 1'b1;
				default: count_o <= count_o;    // Both or neither
			endcase
		end
	end

	assign empty_o       = (count_o == '0);
	assign full_o        = (count_o == (FIFO_AW+1)'(FIFO_DEPTH));
	assign almost_full_o = (count_o > (FIFO_AW+1)'(ALMOST_FULL_LVL));

	a_no_overflow: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wr_en_i |-> !full_o);

	a_no_underflow: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rd_en_i |-> !empty_o);

endmodule

// ==== rtl/result_reader.sv ====
`timescale 1ns/1ps

module result_reader import match_pkg::*; (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic                rd_start_i,
	input  logic [RESULT_W-1:0] fifo_rd_data_i,
	input  logic                fifo_empty_i,
	input  logic [FIFO_AW:0]    fifo_count_i,
	output logic                fifo_rd_en_o,
	output logic                rd_vld_o,
	output logic                rd_eop_o,
	output logic                rd_empty_o,
	output logic [RESULT_W-1:0] rd_data_o
);

	logic draining;
	logic last_pop;                         // Popping the final entry

	assign fifo_rd_en_o = draining && !fifo_empty_i;
	assign last_pop     = fifo_rd_en_o && (fifo_count_i == (FIFO_AW+1)'(1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			draining <= 1'b0;
		end else if (rd_start_i) begin
			draining <= 1'b1;
		end else if (last_pop || fifo_empty_i) begin
			draining <= 1'b0;                   // Nothing left to pop
		end
	end

	////////////////////////////////////////////////////////////
	// Flags aligned to the FIFO read data
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rd_vld_o <= 1'b0;
			rd_eop_o <= 1'b0;
		end else begin
			rd_vld_o <= fifo_rd_en_o;
			rd_eop_o <= last_pop;
		end
	end

	assign rd_data_o  = fifo_rd_data_i;     // Already one cycle after the pop
	assign rd_empty_o = fifo_empty_i;

endmodule

// ==== rtl/matrix_dispatch_top.sv ====
`timescale 1ns/1ps

module matrix_dispatch_top import match_pkg::*; (
	input  logic                              sys_clk,
	input  logic                              sys_rst_n,
	input  logic                              pkt_sop_i,
	input  logic                              pkt_eop_i,
	input  logic                              pkt_vld_i,
	input  logic [DATA_W-1:0]                 pkt_data_i,
	output logic                              pkt_receive_enable_o,
	output logic [NUM_CHAN-1:0]               chan_sop_o,
	output logic [NUM_CHAN-1:0]               chan_eop_o,
	output logic [NUM_CHAN-1:0]               chan_vld_o,
	output logic [NUM_CHAN-1:0][DATA_W-1:0]   chan_data_o,
	input  logic [NUM_CHAN-1:0]               chan_ready_i,
	input  logic [NUM_CHAN-1:0]               chan_result_vld_i,
	input  logic [NUM_CHAN-1:0][RESULT_W-1:0] chan_result_i,
	input  logic                              rd_start_i,
	output logic                              rd_vld_o,
	output logic                              rd_eop_o,
	output logic                              rd_empty_o,
	output logic [RESULT_W-1:0]               rd_data_o
);

	logic                fifo_wr_en;
	logic [RESULT_W-1:0] fifo_wr_data;
	logic                fifo_almost_full;
	logic                fifo_rd_en;
	logic [RESULT_W-1:0] fifo_rd_data;
	logic                fifo_empty;
	logic [FIFO_AW:0]    fifo_count;

	packet_dispatcher u_dispatch (
		.sys_clk              (sys_clk),
		.sys_rst_n            (sys_rst_n),
		.pkt_sop_i            (pkt_sop_i),
		.pkt_eop_i            (pkt_eop_i),
		.pkt_vld_i            (pkt_vld_i),
		.pkt_data_i           (pkt_data_i),
		.chan_ready_i         (chan_ready_i),
		.fifo_almost_full_i   (fifo_almost_full),
		.pkt_receive_enable_o (pkt_receive_enable_o),
		.chan_sop_o           (chan_sop_o),
		.chan_eop_o           (chan_eop_o),
		.chan_vld_o           (chan_vld_o),
		.chan_data_o          (chan_data_o)
	);

	result_slot_mux u_slot (
		.sys_clk           (sys_clk),
		.sys_rst_n         (sys_rst_n),
		.chan_result_vld_i (chan_result_vld_i),
		.chan_result_i     (chan_result_i),
		.fifo_wr_en_o      (fifo_wr_en),
		.fifo_wr_data_o    (fifo_wr_data)
	);

	result_fifo u_fifo (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.wr_en_i       (fifo_wr_en),
		.wr_data_i     (fifo_wr_data),
		.rd_en_i       (fifo_rd_en),
		.rd_data_o     (fifo_rd_data),
		.count_o       (fifo_count),
		.empty_o       (fifo_empty),
		.full_o        (),                  // Overflow caught inside the FIFO
		.almost_full_o (fifo_almost_full)
	);

	result_reader u_reader (
		.sys_clk        (sys_clk),
		.sys_rst_n      (sys_rst_n),
		.rd_start_i     (rd_start_i),
		.fifo_rd_data_i (fifo_rd_data),
		.fifo_empty_i   (fifo_empty),
		.fifo_count_i   (fifo_count),
		.fifo_rd_en_o   (fifo_rd_en),
		.rd_vld_o       (rd_vld_o),
		.rd_eop_o       (rd_eop_o),
		.rd_empty_o     (rd_empty_o),
		.rd_data_o      (rd_data_o)
	);

endmodule

// ==== sim/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic next_cycle();
	@(posedge sys_clk);
	#1;                                      // Drive and sample off the edge
endtask

task automatic check_value(input string name, input logic [RESULT_W-1:0] exp,
		input logic [RESULT_W-1:0] act);
	if (act !== exp) begin
		$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
		err_count++;
	end
endtask

task automatic finish_test(input string name, input int errs_before);
	if (err_count == errs_before) begin
		tests_ok++;
		$display("%s: ok", name);
	end else begin
		tests_bad++;
		$display("%s: %0d errors", name, err_count - errs_before);
	end
endtask

task automatic wait_enable(input string when);
	int n = 0;
	while (!pkt_receive_enable_o && n < WAIT_LIMIT) begin
		next_cycle();
		n++;
	end
	if (!pkt_receive_enable_o) begin
		$display("Receive enable did not rise %s", when);
		err_count++;
	end
endtask

task automatic check_channels(input int chan, input logic sop, input logic eop,
		input logic [DATA_W-1:0] word);
	check_value("chan_vld_o", NUM_CHAN'(1) << chan, chan_vld_o);
	check_value("chan_sop_o", NUM_CHAN'(sop) << chan, chan_sop_o);
	check_value("chan_eop_o", NUM_CHAN'(eop) << chan, chan_eop_o);
	for (int j = 0; j < NUM_CHAN; j++) begin
		check_value($sformatf("chan_data_o[%0d]", j), (j == chan) ? word : '0, chan_data_o[j]);
	end
endtask

task automatic send_packet(input int chan, input int len);
	logic [DATA_W-1:0] word;
	for (int i = 0; i < len; i++) begin
		word       = $urandom;
		pkt_vld_i  = 1'b1;
		pkt_sop_i  = (i == 0);
		pkt_eop_i  = (i == len - 1);
		pkt_data_i = word;
		next_cycle();
		check_channels(chan, i == 0, i == len - 1, word);   // One cycle after presenting
	end
	pkt_vld_i  = 1'b0;
	pkt_sop_i  = 1'b0;
	pkt_eop_i  = 1'b0;
	pkt_data_i = '0;
endtask

// Busy the current channel for one idle cycle so the pointer moves on
task automatic advance_channel();
	chan_ready_i[exp_chan] = 1'b0;
	next_cycle();
	chan_ready_i[exp_chan] = 1'b1;
	exp_chan = (exp_chan + 1) % NUM_CHAN;
endtask

task automatic post_result(input int chan, input logic [RESULT_W-1:0] data);
	chan_result_vld_i[chan] = 1'b1;
	chan_result_i[chan]     = data;
	exp_q.push_back(data);
	repeat (NUM_CHAN) next_cycle();          // One full slot rotation
	chan_result_vld_i[chan] = 1'b0;
endtask

task automatic drain_and_check();
	int n     = 0;
	bit done  = 1'b0;
	check_value("rd_empty_o", exp_q.size() == 0, rd_empty_o);   // Posted words waiting
	rd_start_i = 1'b1;
	next_cycle();
	rd_start_i = 1'b0;
	while (!done && n < WAIT_LIMIT) begin
		if (rd_vld_o && exp_q.size() == 0) begin
			$display("Reader delivered a word that was never posted");
			err_count++;
			done = 1'b1;
		end else if (rd_vld_o) begin
			check_value("rd_data_o", exp_q.pop_front(), rd_data_o);
			check_value("rd_eop_o", exp_q.size() == 0, rd_eop_o);
			done = rd_eop_o;
		end
		if (!done) begin
			next_cycle();
			n++;
		end
	end
	if (!done) begin
		$display("Reader never flagged the last word with rd_eop_o");
		err_count++;
	end
	if (exp_q.size() != 0) begin
		$display("Reader ended the drain with %0d posted words still missing", exp_q.size());
		err_count++;
	end
	exp_q.delete();
	next_cycle();
	check_value("rd_vld_o", 1'b0, rd_vld_o);
	check_value("rd_empty_o", 1'b1, rd_empty_o);
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic check_reset_state();
	int errs = err_count;
	check_value("pkt_receive_enable_o", 1'b0, pkt_receive_enable_o);
	check_value("chan_vld_o", '0, chan_vld_o);
	check_value("rd_vld_o", 1'b0, rd_vld_o);
	check_value("rd_empty_o", 1'b1, rd_empty_o);
	finish_test("reset state", errs);
endtask

task automatic test_routing();
	int errs = err_count;
	wait_enable("after reset");
	send_packet(exp_chan, 4);
	next_cycle();
	check_value("chan_vld_o", '0, chan_vld_o);   // Bus idle again
	finish_test("routing", errs);
endtask

task automatic test_round_robin();
	int errs = err_count;
	for (int k = 0; k < NUM_CHAN; k++) begin
		advance_channel();
		wait_enable("after a channel change");
		send_packet(exp_chan, 1 + $urandom % 4);
	end
	finish_test("round robin", errs);
endtask

task automatic test_collect_drain();
	int errs = err_count;
	for (int k = 0; k < 9; k++) begin
		post_result($urandom % NUM_CHAN, {$urandom, $urandom});
	end
	repeat (2) next_cycle();                 // Let the last write land
	drain_and_check();
	finish_test("collect and drain", errs);
endtask

task automatic test_back_pressure();
	int errs = err_count;
	int n    = 0;
	for (int k = 0; k < 13; k++) begin
		post_result(k % NUM_CHAN, {$urandom, $urandom});
	end
	repeat (2) next_cycle();
	wait_enable("before the packet start");
	send_packet(exp_chan, 1);
	while (pkt_receive_enable_o && n < 2) begin
		next_cycle();
		n++;
	end
	if (pkt_receive_enable_o) begin
		$display("Receive enable stayed high with the FIFO almost full");
		err_count++;
	end
	drain_and_check();
	wait_enable("after the drain");
	finish_test("back-pressure", errs);
endtask

`endif

// ==== sim/tb_matrix_dispatch.sv ====
`timescale 1ns/1ps

module tb_matrix_dispatch import match_pkg::*; ();

	localparam int TEST_CYCLES     = 16 + 100 + 700 + 500 + 700;   // Reset plus four tests
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;
	localparam int WAIT_LIMIT      = 40;                            // Cycles for any one event

	logic                              sys_clk;
	logic                              sys_rst_n;
	logic                              pkt_sop_i;
	logic                              pkt_eop_i;
	logic                              pkt_vld_i;
	logic [DATA_W-1:0]                 pkt_data_i;
	logic                              pkt_receive_enable_o;
	logic [NUM_CHAN-1:0]               chan_sop_o;
	logic [NUM_CHAN-1:0]               chan_eop_o;
	logic [NUM_CHAN-1:0]               chan_vld_o;
	logic [NUM_CHAN-1:0][DATA_W-1:0]   chan_data_o;
	logic [NUM_CHAN-1:0]               chan_ready_i;
	logic [NUM_CHAN-1:0]               chan_result_vld_i;
	logic [NUM_CHAN-1:0][RESULT_W-1:0] chan_result_i;
	logic                              rd_start_i;
	logic                              rd_vld_o;
	logic                              rd_eop_o;
	logic                              rd_empty_o;
	logic [RESULT_W-1:0]               rd_data_o;

	int                  err_count = 0;
	int                  tests_ok  = 0;
	int                  tests_bad = 0;
	int                  exp_chan  = 0;  // Channel the pointer should select
	logic [RESULT_W-1:0] exp_q [$];      // Posted results in posting order

	matrix_dispatch_top dut0 (.*);

	`include "tb_tasks.svh"

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hf0695ad4));
		sys_rst_n         = 1'b0;
		pkt_sop_i         = 1'b0;
		pkt_eop_i         = 1'b0;
		pkt_vld_i         = 1'b0;
		pkt_data_i        = '0;
		chan_ready_i      = '1;      // All channels free from the start
		chan_result_vld_i = '0;
		chan_result_i     = '0;
		rd_start_i        = 1'b0;
		repeat (15) @(posedge sys_clk);
		#1;
		check_reset_state();
		next_cycle();
		sys_rst_n = 1'b1;            // Released after 16 edges
		test_routing();
		test_round_robin();
		test_collect_drain();
		test_back_pressure();
		$display("Summary: %0d tests ok, %0d tests with errors, %0d errors",
			tests_ok, tests_bad, err_count);
		if (tests_bad == 0 && err_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+sim
rtl/match_pkg.sv
rtl/packet_dispatcher.sv
rtl/result_slot_mux.sv
rtl/result_fifo.sv
rtl/result_reader.sv
rtl/matrix_dispatch_top.sv
sim/tb_matrix_dispatch.sv

// ==== Bender.yml ====
package:
  name: matrix_dispatch

sources:
  - rtl/match_pkg.sv
  - rtl/packet_dispatcher.sv
  - rtl/result_slot_mux.sv
  - rtl/result_fifo.sv
  - rtl/result_reader.sv
  - rtl/matrix_dispatch_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_matrix_dispatch.sv
